//--- src/phased_mem_defines.svh
`ifndef PHASED_MEM_DEFINES_SVH
`define PHASED_MEM_DEFINES_SVH

// Host command port credits, equal to the command buffer depth
`define CMD_CREDITS 4

// Host command fields
`define ADDR_W 14
`define DATA_W 16

// Controller register bank
`define CTL_ADDR_W 8
`define CTL_WORDS 256

// Modulation and duty tables
`define TBL_W 8
`define TBL_IDX_W 8

// Segments of the modulation table
`define MOD_SEGMENTS 2

// Pages of the duty table
`define DUTY_PAGES 2

`endif

//--- src/phased_mem_pkg.sv
`default_nettype none

package phased_mem_pkg;

  // Bank targeted by a host command, code 3 is unused
  typedef enum logic [1:0] {
    BANK_CTL  = 2'd0,
    BANK_MOD  = 2'd1,
    BANK_DUTY = 2'd2
  } bank_sel_e;

  // Host command opcode
  typedef enum logic {
    CMD_WRITE = 1'b0,
    CMD_READ  = 1'b1
  } cmd_op_e;

  // Decoded addresses inside the controller bank
  typedef enum logic [7:0] {
    ADDR_MOD_WR_SEGMENT = 8'h10,
    ADDR_DUTY_WR_PAGE   = 8'h11
  } ctl_addr_e;

endpackage

`default_nettype wire

//--- src/cmd_buffer.sv
`timescale 1ns/10ps
`default_nettype none
`include "phased_mem_defines.svh"

module cmd_buffer (
  input  wire                        bus_clk,
  input  wire                        arst_n,
  input  wire                        cmd_valid,
  input  wire phased_mem_pkg::cmd_op_e   cmd_op,
  input  wire phased_mem_pkg::bank_sel_e cmd_sel,
  input  wire [`ADDR_W-1:0]          cmd_addr,
  input  wire [`DATA_W-1:0]          cmd_data,
  output logic                       head_valid,
  output phased_mem_pkg::cmd_op_e    head_op,
  output phased_mem_pkg::bank_sel_e  head_sel,
  output logic [`ADDR_W-1:0]         head_addr,
  output logic [`DATA_W-1:0]         head_data,
  output logic                       credit_return
);

  import phased_mem_pkg::*;

  localparam int PTR_W = $clog2(`CMD_CREDITS);
  localparam int CNT_W = $clog2(`CMD_CREDITS + 1);

  cmd_op_e            op_q   [`CMD_CREDITS];
  bank_sel_e          sel_q  [`CMD_CREDITS];
  logic [`ADDR_W-1:0] addr_q [`CMD_CREDITS];
  logic [`DATA_W-1:0] data_q [`CMD_CREDITS];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Downstream never stalls, so the head leaves whenever present
  assign head_valid = (count != '0);
  assign head_op    = op_q[rd_ptr];
  assign head_sel   = sel_q[rd_ptr];
  assign head_addr  = addr_q[rd_ptr];
  assign head_data  = data_q[rd_ptr];

  always_ff @(posedge bus_clk) begin
    if (cmd_valid) begin
      op_q[wr_ptr]   <= cmd_op;
      sel_q[wr_ptr]  <= cmd_sel;
      addr_q[wr_ptr] <= cmd_addr;
      data_q[wr_ptr] <= cmd_data;
    end
  end

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (cmd_valid) wr_ptr <= wr_ptr + PTR_W'(1);
      if (head_valid) rd_ptr <= rd_ptr + PTR_W'(1);
      if (cmd_valid && !head_valid) count <= count + CNT_W'(1);
      else if (!cmd_valid && head_valid) count <= count - CNT_W'(1);
      // One credit back per released entry
      credit_return <= head_valid;
    end
  end

endmodule

`default_nettype wire

//--- src/bank_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "phased_mem_defines.svh"

module bank_decode (
  input  wire                            bus_clk,
  input  wire                            arst_n,
  input  wire                            head_valid,
  input  wire phased_mem_pkg::cmd_op_e   head_op,
  input  wire phased_mem_pkg::bank_sel_e head_sel,
  input  wire [`ADDR_W-1:0]              head_addr,
  input  wire [`DATA_W-1:0]              head_data,
  output logic                           ctl_we,
  output logic                           ctl_re,
  output logic [`CTL_ADDR_W-1:0]         ctl_addr,
  output logic [`DATA_W-1:0]             ctl_wdata,
  output logic                           mod_we,
  output logic                           mod_wr_segment,
  output logic [`TBL_IDX_W-1:0]          mod_wr_addr,
  output logic                           duty_we,
  output logic                           duty_wr_page,
  output logic [`TBL_IDX_W-1:0]          duty_wr_addr,
  output logic [`TBL_W-1:0]              wdata_lo
);

  import phased_mem_pkg::*;

  logic sub_main;
  logic is_wr;
  logic is_rd;
  logic mod_seg_q;
  logic duty_page_q;

  // Sub-bank field in bits 13..8 must select the main controller bank
  assign sub_main = (head_addr[`ADDR_W-1:`CTL_ADDR_W] == '0);
  assign is_wr    = head_valid && (head_op == CMD_WRITE);
  assign is_rd    = head_valid && (head_op == CMD_READ);

  // Table writes carry the segment and page currently in force
  assign mod_wr_segment = mod_seg_q;
  assign duty_wr_page   = duty_page_q;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      ctl_we  <= 1'b0;
      ctl_re  <= 1'b0;
      mod_we  <= 1'b0;
      duty_we <= 1'b0;
    end else begin
      ctl_we  <= is_wr && (head_sel == BANK_CTL) && sub_main;
      // Readback exists only for the controller bank
      ctl_re  <= is_rd && (head_sel == BANK_CTL) && sub_main;
      mod_we  <= is_wr && (head_sel == BANK_MOD);
      duty_we <= is_wr && (head_sel == BANK_DUTY);
    end
  end

  always_ff @(posedge bus_clk) begin
    ctl_addr     <= head_addr[`CTL_ADDR_W-1:0];
    ctl_wdata    <= head_data;
    mod_wr_addr  <= head_addr[`TBL_IDX_W-1:0];
    duty_wr_addr <= head_addr[`TBL_IDX_W-1:0];
    wdata_lo     <= head_data[`TBL_W-1:0];
  end

  // Write segment and page follow the registered controller write
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      mod_seg_q   <= 1'b0;
      duty_page_q <= 1'b0;
    end else if (ctl_we) begin
      case (ctl_addr)
        ADDR_MOD_WR_SEGMENT: mod_seg_q <= ctl_wdata[0];
        ADDR_DUTY_WR_PAGE:   duty_page_q <= ctl_wdata[0];
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/ctl_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "phased_mem_defines.svh"

module ctl_regfile (
  input  wire                    bus_clk,
  input  wire                    arst_n,
  input  wire                    ctl_we,
  input  wire                    ctl_re,
  input  wire [`CTL_ADDR_W-1:0]  ctl_addr,
  input  wire [`DATA_W-1:0]      ctl_wdata,
  output logic                   rd_valid,
  output logic [`DATA_W-1:0]     rd_data
);

  logic [`DATA_W-1:0] regs [`CTL_WORDS];

  // Whole bank starts at zero, including segment and page copies
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CTL_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctl_we) begin
      regs[ctl_addr] <= ctl_wdata;
    end
  end

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= ctl_re;
    end
  end

  // Read data held until the next readback
  always_ff @(posedge bus_clk) begin
    if (ctl_re) begin
      rd_data <= regs[ctl_addr];
    end
  end

endmodule

`default_nettype wire

//--- src/pattern_mem.sv
`timescale 1ns/10ps
`default_nettype none
`include "phased_mem_defines.svh"

module pattern_mem (
  input  wire                   bus_clk,
  input  wire                   mod_we,
  input  wire                   mod_wr_segment,
  input  wire [`TBL_IDX_W-1:0]  mod_wr_addr,
  input  wire                   duty_we,
  input  wire                   duty_wr_page,
  input  wire [`TBL_IDX_W-1:0]  duty_wr_addr,
  input  wire [`TBL_W-1:0]      wdata_lo,
  input  wire                   mod_rd_segment,
  input  wire [`TBL_IDX_W-1:0]  mod_rd_idx,
  input  wire [`TBL_IDX_W:0]    duty_rd_idx,
  output logic [`TBL_W-1:0]     mod_rd_value,
  output logic [`TBL_W-1:0]     duty_rd_value
);

  localparam int TBL_DEPTH  = 1 << `TBL_IDX_W;
  localparam int DUTY_DEPTH = `DUTY_PAGES * TBL_DEPTH;

  logic [`TBL_W-1:0] seg_rd_value [`MOD_SEGMENTS];
  logic              rd_segment_q;

  logic [`TBL_W-1:0] duty_mem [DUTY_DEPTH];

  // One block RAM per modulation segment
  for (genvar s = 0; s < `MOD_SEGMENTS; s++) begin : gen_mod_seg
    logic [`TBL_W-1:0] mod_mem [TBL_DEPTH];
    logic              seg_we;

    assign seg_we = mod_we && (mod_wr_segment == s[0]);

    always_ff @(posedge bus_clk) begin
      if (seg_we) begin
        mod_mem[mod_wr_addr] <= wdata_lo;
      end
    end

    // Every segment reads the same index in parallel
    always_ff @(posedge bus_clk) begin
      seg_rd_value[s] <= mod_mem[mod_rd_idx];
    end
  end

  // Segment chosen alongside the registered read
  always_ff @(posedge bus_clk) begin
    rd_segment_q <= mod_rd_segment;
  end

  assign mod_rd_value = seg_rd_value[rd_segment_q];

  // Page is the top address bit on both sides
  always_ff @(posedge bus_clk) begin
    if (duty_we) begin
      duty_mem[{duty_wr_page, duty_wr_addr}] <= wdata_lo;
    end
  end

  always_ff @(posedge bus_clk) begin
    duty_rd_value <= duty_mem[duty_rd_idx];
  end

endmodule

`default_nettype wire

//--- src/phased_mem_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "phased_mem_defines.svh"

module phased_mem_top (
  input  wire                            bus_clk,
  input  wire                            arst_n,
  input  wire                            cmd_valid,
  input  wire phased_mem_pkg::cmd_op_e   cmd_op,
  input  wire phased_mem_pkg::bank_sel_e cmd_sel,
  input  wire [`ADDR_W-1:0]              cmd_addr,
  input  wire [`DATA_W-1:0]              cmd_data,
  output logic                           credit_return,
  output logic                           rd_valid,
  output logic [`DATA_W-1:0]             rd_data,
  input  wire                            mod_rd_segment,
  input  wire [`TBL_IDX_W-1:0]           mod_rd_idx,
  input  wire [`TBL_IDX_W:0]             duty_rd_idx,
  output logic [`TBL_W-1:0]              mod_rd_value,
  output logic [`TBL_W-1:0]              duty_rd_value
);

  import phased_mem_pkg::*;

  // Buffer head towards the decoder
  logic               head_valid;
  cmd_op_e            head_op;
  bank_sel_e          head_sel;
  logic [`ADDR_W-1:0] head_addr;
  logic [`DATA_W-1:0] head_data;

  // Decoded strobes towards storage
  logic                   ctl_we;
  logic                   ctl_re;
  logic [`CTL_ADDR_W-1:0] ctl_addr;
  logic [`DATA_W-1:0]     ctl_wdata;
  logic                   mod_we;
  logic                   mod_wr_segment;
  logic [`TBL_IDX_W-1:0]  mod_wr_addr;
  logic                   duty_we;
  logic                   duty_wr_page;
  logic [`TBL_IDX_W-1:0]  duty_wr_addr;
  logic [`TBL_W-1:0]      wdata_lo;

  cmd_buffer cmd_buffer_i (
    .bus_clk      (bus_clk),
    .arst_n       (arst_n),
    .cmd_valid    (cmd_valid),
    .cmd_op       (cmd_op),
    .cmd_sel      (cmd_sel),
    .cmd_addr     (cmd_addr),
    .cmd_data     (cmd_data),
    .head_valid   (head_valid),
    .head_op      (head_op),
    .head_sel     (head_sel),
    .head_addr    (head_addr),
    .head_data    (head_data),
    .credit_return(credit_return)
  );

  bank_decode bank_decode_i (
    .bus_clk       (bus_clk),
    .arst_n        (arst_n),
    .head_valid    (head_valid),
    .head_op       (head_op),
    .head_sel      (head_sel),
    .head_addr     (head_addr),
    .head_data     (head_data),
    .ctl_we        (ctl_we),
    .ctl_re        (ctl_re),
    .ctl_addr      (ctl_addr),
    .ctl_wdata     (ctl_wdata),
    .mod_we        (mod_we),
    .mod_wr_segment(mod_wr_segment),
    .mod_wr_addr   (mod_wr_addr),
    .duty_we       (duty_we),
    .duty_wr_page  (duty_wr_page),
    .duty_wr_addr  (duty_wr_addr),
    .wdata_lo      (wdata_lo)
  );

  ctl_regfile ctl_regfile_i (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .ctl_we   (ctl_we),
    .ctl_re   (ctl_re),
    .ctl_addr (ctl_addr),
    .ctl_wdata(ctl_wdata),
    .rd_valid (rd_valid),
    .rd_data  (rd_data)
  );

  pattern_mem pattern_mem_i (
    .bus_clk       (bus_clk),
    .mod_we        (mod_we),
    .mod_wr_segment(mod_wr_segment),
    .mod_wr_addr   (mod_wr_addr),
    .duty_we       (duty_we),
    .duty_wr_page  (duty_wr_page),
    .duty_wr_addr  (duty_wr_addr),
    .wdata_lo      (wdata_lo),
    .mod_rd_segment(mod_rd_segment),
    .mod_rd_idx    (mod_rd_idx),
    .duty_rd_idx   (duty_rd_idx),
    .mod_rd_value  (mod_rd_value),
    .duty_rd_value (duty_rd_value)
  );

endmodule

`default_nettype wire

//--- test/phased_mem_assert.sv
`timescale 1ns/10ps
`default_nettype none
`include "phased_mem_defines.svh"

module phased_mem_assert (
  input wire                                 bus_clk,
  input wire                                 arst_n,
  input wire                                 cmd_valid,
  input wire                                 credit_return,
  input wire [$clog2(`CMD_CREDITS + 1)-1:0]  occupancy,
  input wire                                 ctl_we,
  input wire                                 mod_we,
  input wire                                 duty_we,
  input wire                                 rd_valid
);

  localparam int OUT_W = $clog2(`CMD_CREDITS + 1) + 1;

  logic             any_strobe;
  logic [OUT_W-1:0] outstanding;

  assign any_strobe = ctl_we || mod_we || duty_we || rd_valid;

  // Commands taken from the host whose credit has not come back yet
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= '0;
    end else begin
      outstanding <= outstanding + OUT_W'(cmd_valid) - OUT_W'(credit_return);
    end
  end

  // A credit only comes back for a command still owed one
  credit_owed: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    credit_return |-> (outstanding != '0)
  ) else $error("credit_return with no command awaiting a credit");

  // Host never has more commands in flight than credits
  credit_limit: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    outstanding <= OUT_W'(`CMD_CREDITS)
  ) else $error("command sent while the buffer was full");

  occupancy_bound: assert property (
    @(posedge bus_clk) disable iff (!arst_n)
    occupancy <= outstanding
  ) else $error("command buffer holds more entries than credits taken");

  // Quiet during reset and the first cycle out of it
  reset_quiet: assert property (
    @(posedge bus_clk)
    (!arst_n || $rose(arst_n)) |-> !any_strobe
  ) else $error("strobe or rd_valid high around reset");

endmodule

`default_nettype wire

//--- test/phased_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "phased_mem_defines.svh"

module phased_mem_tb;

  import phased_mem_pkg::*;

  // Host commands and consumer reads issued over all tests
  localparam int N_CMDS      = 65;
  localparam int N_TBL_READS = 64;
  localparam int CYCLE_LIMIT = 2 * (N_CMDS + N_TBL_READS) + 400;
  localparam int N_WR        = 8;
  localparam int SUB_W       = `ADDR_W - `CTL_ADDR_W;

  logic                  bus_clk;
  logic                  arst_n;
  logic                  cmd_valid;
  cmd_op_e               cmd_op;
  bank_sel_e             cmd_sel;
  logic [`ADDR_W-1:0]    cmd_addr;
  logic [`DATA_W-1:0]    cmd_data;
  logic                  credit_return;
  logic                  rd_valid;
  logic [`DATA_W-1:0]    rd_data;
  logic                  mod_rd_segment;
  logic [`TBL_IDX_W-1:0] mod_rd_idx;
  logic [`TBL_IDX_W:0]   duty_rd_idx;
  logic [`TBL_W-1:0]     mod_rd_value;
  logic [`TBL_W-1:0]     duty_rd_value;

  // Host bookkeeping and bank models
  int                    credits;
  int                    pulses;
  int                    cycles = 0;
  logic [15:0]           lfsr;
  logic [`DATA_W-1:0]    ctl_model [`CTL_WORDS];
  logic [`TBL_W-1:0]     mod_model [`MOD_SEGMENTS][1 << `TBL_IDX_W];
  logic [`TBL_W-1:0]     duty_model [`DUTY_PAGES * (1 << `TBL_IDX_W)];
  logic [`TBL_IDX_W-1:0] mod_idx [`MOD_SEGMENTS][N_WR];
  logic [`TBL_IDX_W-1:0] duty_idx [`DUTY_PAGES][N_WR];
  logic                  mod_seg;
  logic                  duty_page;
  logic [`DATA_W-1:0]    rd_q [$];
  logic [`DATA_W-1:0]    exp_q [$];

  phased_mem_top dut_i (
    .bus_clk       (bus_clk),
    .arst_n        (arst_n),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_sel       (cmd_sel),
    .cmd_addr      (cmd_addr),
    .cmd_data      (cmd_data),
    .credit_return (credit_return),
    .rd_valid      (rd_valid),
    .rd_data       (rd_data),
    .mod_rd_segment(mod_rd_segment),
    .mod_rd_idx    (mod_rd_idx),
    .duty_rd_idx   (duty_rd_idx),
    .mod_rd_value  (mod_rd_value),
    .duty_rd_value (duty_rd_value)
  );

  bind phased_mem_top phased_mem_assert assert_i (
    .bus_clk      (bus_clk),
    .arst_n       (arst_n),
    .cmd_valid    (cmd_valid),
    .credit_return(credit_return),
    .occupancy    (cmd_buffer_i.count),
    .ctl_we       (ctl_we),
    .mod_we       (mod_we),
    .duty_we      (duty_we),
    .rd_valid     (rd_valid)
  );

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;
  end

  // Credits and read responses sampled on the falling edge
  always @(negedge bus_clk) begin
    if (arst_n && credit_return) begin
      credits = credits + 1;
      pulses  = pulses + 1;
    end
    if (arst_n && rd_valid) begin
      rd_q.push_back(rd_data);
    end
  end

  always @(posedge bus_clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`DATA_W-1:0] exp_v,
                            input logic [`DATA_W-1:0] act_v);
    if (act_v !== exp_v) begin
      fail_run($sformatf("Error at %0t: %s expected 0x%04h, got 0x%04h",
                         $time, name, exp_v, act_v));
    end
  endtask

  task automatic check_value(input string name, input logic [`TBL_W-1:0] exp_v,
                             input logic [`TBL_W-1:0] act_v);
    if (act_v !== exp_v) begin
      fail_run($sformatf("Error at %0t: %s expected 0x%02h, got 0x%02h",
                         $time, name, exp_v, act_v));
    end
  endtask

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [`DATA_W-1:0] take_bits(input int n);
    logic [`DATA_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v = {v[`DATA_W-2:0], lfsr[0]};
    end
    return v;
  endfunction

  // One command per cycle while a credit is held
  task automatic send_cmd(input cmd_op_e op, input bank_sel_e sel,
                          input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
    @(posedge bus_clk);
    while (credits == 0) begin
      cmd_valid <= 1'b0;
      @(posedge bus_clk);
    end
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_sel   <= sel;
    cmd_addr  <= addr;
    cmd_data  <= data;
    credits = credits - 1;
  endtask

  task automatic wait_drain();
    @(posedge bus_clk);
    cmd_valid <= 1'b0;
    while (credits != `CMD_CREDITS) begin
      @(posedge bus_clk);
    end
    // Storage write and readback land two cycles after the pop
    repeat (3) @(posedge bus_clk);
  endtask

  task automatic ctl_write(input logic [`CTL_ADDR_W-1:0] a, input logic [`DATA_W-1:0] d);
    send_cmd(CMD_WRITE, BANK_CTL, {{SUB_W{1'b0}}, a}, d);
    ctl_model[a] = d;
    if (a == ADDR_MOD_WR_SEGMENT) begin
      mod_seg = d[0];
    end
    if (a == ADDR_DUTY_WR_PAGE) begin
      duty_page = d[0];
    end
  endtask

  task automatic ctl_read(input logic [`CTL_ADDR_W-1:0] a);
    send_cmd(CMD_READ, BANK_CTL, {{SUB_W{1'b0}}, a}, '0);
    exp_q.push_back(ctl_model[a]);
  endtask

  task automatic check_reads();
    logic [`DATA_W-1:0] got;
    if (rd_q.size() != exp_q.size()) begin
      fail_run($sformatf("Expected %0d read responses but %0d arrived",
                         exp_q.size(), rd_q.size()));
    end
    while (exp_q.size() > 0) begin
      got = rd_q.pop_front();
      check_word("rd_data", exp_q.pop_front(), got);
    end
  endtask

  task automatic check_credits(input int p0, input int n);
    if (pulses - p0 != n) begin
      fail_run($sformatf("Expected %0d credit pulses but %0d arrived", n, pulses - p0));
    end
  endtask

  task automatic read_mod(input logic seg, input logic [`TBL_IDX_W-1:0] idx);
    @(posedge bus_clk);
    mod_rd_segment <= seg;
    mod_rd_idx     <= idx;
    @(posedge bus_clk);
    @(negedge bus_clk);
    check_value("mod_rd_value", mod_model[seg][idx], mod_rd_value);
  endtask

  task automatic read_duty(input logic page, input logic [`TBL_IDX_W-1:0] idx);
    @(posedge bus_clk);
    duty_rd_idx <= {page, idx};
    @(posedge bus_clk);
    @(negedge bus_clk);
    check_value("duty_rd_value", duty_model[{page, idx}], duty_rd_value);
  endtask

  task automatic check_tables();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < N_WR; i++) begin
        read_mod(p[0], mod_idx[p][i]);
        read_duty(p[0], duty_idx[p][i]);
      end
    end
  endtask

  task automatic test_reset_credits();
    int p0;
    repeat (6) begin
      @(negedge bus_clk);
      if (credit_return !== 1'b0 || rd_valid !== 1'b0) begin
        fail_run("credit_return or rd_valid went high while idle after reset");
      end
    end
    p0 = pulses;
    for (int i = 0; i < `CMD_CREDITS; i++) begin
      ctl_write(8'(64 + i), take_bits(16));
    end
    wait_drain();
    check_credits(p0, `CMD_CREDITS);
  endtask

  task automatic test_ctl_readback();
    logic [`CTL_ADDR_W-1:0] addrs [N_WR];
    for (int i = 0; i < N_WR; i++) begin
      addrs[i] = 8'(take_bits(8));
      // Keep clear of the segment and page registers
      if (addrs[i] == ADDR_MOD_WR_SEGMENT || addrs[i] == ADDR_DUTY_WR_PAGE) begin
        addrs[i] = addrs[i] ^ 8'h80;
      end
      ctl_write(addrs[i], take_bits(16));
    end
    for (int i = 0; i < N_WR; i++) begin
      ctl_read(addrs[i]);
    end
    wait_drain();
    check_reads();
  endtask

  task automatic fill_tables(input logic is_duty);
    logic [`DATA_W-1:0] d;
    for (int p = 0; p < 2; p++) begin
      ctl_write(is_duty ? ADDR_DUTY_WR_PAGE : ADDR_MOD_WR_SEGMENT, 16'(p));
      for (int i = 0; i < N_WR; i++) begin
        d = take_bits(16);
        if (is_duty) begin
          duty_idx[p][i] = 8'(take_bits(8));
          send_cmd(CMD_WRITE, BANK_DUTY, {{SUB_W{1'b0}}, duty_idx[p][i]}, d);
          duty_model[{duty_page, duty_idx[p][i]}] = d[`TBL_W-1:0];
        end else begin
          mod_idx[p][i] = 8'(take_bits(8));
          send_cmd(CMD_WRITE, BANK_MOD, {{SUB_W{1'b0}}, mod_idx[p][i]}, d);
          mod_model[mod_seg][mod_idx[p][i]] = d[`TBL_W-1:0];
        end
      end
    end
    wait_drain();
  endtask

  task automatic test_dropped();
    logic [SUB_W-1:0] sub;
    int               p0;
    sub = 6'(take_bits(6));
    if (sub == '0) begin
      sub = 6'd1;
    end
    p0 = pulses;
    // Targets sit in the segment and page now in force, so a stray write shows up
    send_cmd(CMD_READ, BANK_MOD, {{SUB_W{1'b0}}, mod_idx[1][0]}, take_bits(16));
    send_cmd(CMD_WRITE, BANK_CTL, {sub, 8'h30}, take_bits(16));
    send_cmd(CMD_READ, BANK_CTL, {sub, 8'h30}, '0);
    send_cmd(CMD_WRITE, bank_sel_e'(2'd3), {{SUB_W{1'b0}}, mod_idx[1][0]}, take_bits(16));
    send_cmd(CMD_WRITE, bank_sel_e'(2'd3), {{SUB_W{1'b0}}, duty_idx[1][0]}, take_bits(16));
    wait_drain();
    check_credits(p0, 5);
    if (rd_q.size() != 0) begin
      fail_run("A dropped read returned a response");
    end
    ctl_read(8'h30);
    wait_drain();
    check_reads();
    check_tables();
  endtask

  initial begin
    arst_n         = 1'b0;
    cmd_valid      = 1'b0;
    cmd_op         = CMD_WRITE;
    cmd_sel        = BANK_CTL;
    cmd_addr       = '0;
    cmd_data       = '0;
    mod_rd_segment = 1'b0;
    mod_rd_idx     = '0;
    duty_rd_idx    = '0;
    credits        = `CMD_CREDITS;
    pulses         = 0;
    lfsr           = 16'd64846;
    mod_seg        = 1'b0;
    duty_page      = 1'b0;
    for (int i = 0; i < `CTL_WORDS; i++) begin
      ctl_model[i] = '0;
    end
    repeat (4) @(posedge bus_clk);
    arst_n <= 1'b1;

    test_reset_credits();
    test_ctl_readback();
    fill_tables(1'b0);
    fill_tables(1'b1);
    check_tables();
    test_dropped();
    // Segment and page copies read back from the controller bank
    ctl_write(ADDR_DUTY_WR_PAGE, take_bits(16));
    ctl_read(ADDR_MOD_WR_SEGMENT);
    ctl_read(ADDR_DUTY_WR_PAGE);
    wait_drain();
    check_reads();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- phased_mem_top.f
+incdir+src
src/phased_mem_pkg.sv
src/cmd_buffer.sv
src/bank_decode.sv
src/ctl_regfile.sv
src/pattern_mem.sv
src/phased_mem_top.sv
test/phased_mem_assert.sv
test/phased_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the phased_mem testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module phased_mem_tb \
  -f phased_mem_top.f \
  -o phased_mem_sim

# The log decides the result, so a nonzero exit must not stop the script here
./obj_dir/phased_mem_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  echo "Result: failure reported by the testbench"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "Result: run ended without completing"
  exit 1
fi
echo "Result: all checks completed"
